/* vlog.f */
common/npc_pkg.sv
design/fetch_unit.sv
design/gpr_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/lsu.sv
design/mem_arbiter.sv
design/npc_core.sv
verification/npc_checker.sv
verification/tb_clock.sv
verification/tb_monitor.sv
verification/tb_top.sv

/* verification/tb_top.sv */
// testbench top, program and expectation tables, word memory model and watchdog
`timescale 1ns/100ps

module tb_top
	import npc_pkg::*;
();

	localparam int N_PROG    = 23;
	localparam int N_RET     = 19;
	localparam int N_ST      = 2;
	localparam int MEM_WORDS = 256;
	// reset plus 20 cycles per expected instruction
	localparam int TIMEOUT_CYCLES = 8 + N_RET * 20;

	logic                   clk;
	logic                   rst;
	mem_req_t               mem_req;
	mem_rsp_t               mem_rsp;
	retire_t                retire;
	logic [31:0]            mem [MEM_WORDS];
	logic [31:0]            prog [N_PROG];
	logic [N_RET-1:0][69:0] exp_ret;
	logic [N_ST-1:0][63:0]  exp_st;
	logic                   done;
	int                     err_count;
	int                     ret_count;
	int                     assert_fails;

	// ****************************************
	// rv32i encoders
	// ****************************************
	function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
		input int rd, input int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_u(input int imm, input int rd);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// background word, every address bit matters
	function automatic logic [31:0] fill_word(input int addr);
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic [69:0] ret_entry(input int pc, input int rd, input int we,
		input logic [31:0] value);
		return {pc[31:0], rd[4:0], we[0], value};
	endfunction

	// ****************************************
	// tables
	// ****************************************
	initial begin : load_tables
		int i;
		mem_rsp = '0;
		prog[0]  = enc_i(5, 0, 0, 1, 7'h13);         // addi x1, x0, 5
		prog[1]  = enc_i(-3, 1, 0, 2, 7'h13);        // addi x2, x1, -3
		prog[2]  = enc_r(0, 2, 1, 3);                // add x3, x1, x2
		prog[3]  = enc_r(7'h20, 1, 2, 4);            // sub x4, x2, x1
		prog[4]  = enc_u(32'h12345, 5);              // lui x5
		prog[5]  = enc_i(9, 1, 0, 0, 7'h13);         // addi x0, x1, 9
		prog[6]  = enc_r(0, 5, 0, 15);               // add x15, x0, x5
		prog[7]  = enc_i(32'h100, 0, 0, 6, 7'h13);   // addi x6, x0, 0x100
		prog[8]  = enc_s(8, 4, 6);                   // sw x4, 8(x6)
		prog[9]  = enc_i(8, 6, 2, 7, 7'h03);         // lw x7, 8(x6)
		prog[10] = enc_i(1, 7, 0, 8, 7'h13);         // addi x8, x7, 1
		prog[11] = enc_b(8, 2, 1);                   // beq x1, x2, not taken
		prog[12] = enc_b(12, 3, 3);                  // beq x3, x3, to 0x3c
		prog[13] = enc_i(1, 0, 0, 9, 7'h13);
		prog[14] = enc_i(2, 0, 0, 9, 7'h13);
		prog[15] = enc_j(12, 10);                    // jal x10, to 0x48
		prog[16] = enc_i(7, 0, 0, 11, 7'h13);
		prog[17] = enc_i(8, 0, 0, 11, 7'h13);
		prog[18] = enc_i(0, 6, 2, 12, 7'h03);        // lw x12, 0(x6)
		prog[19] = enc_r(0, 10, 12, 13);             // add x13, x12, x10
		prog[20] = enc_s(12, 13, 6);                 // sw x13, 12(x6)
		prog[21] = enc_i(12, 6, 2, 14, 7'h03);       // lw x14, 12(x6)
		prog[22] = enc_j(0, 0);                      // jal x0, self loop
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(i * 4);
		end
		for (i = 0; i < N_PROG; i++) begin
			mem[i] = prog[i];
		end
		// expected retire sequence, rd and value only count when we is set
		exp_ret[0]  = ret_entry(32'h00, 1, 1, 32'd5);
		exp_ret[1]  = ret_entry(32'h04, 2, 1, 32'd2);
		exp_ret[2]  = ret_entry(32'h08, 3, 1, 32'd7);
		exp_ret[3]  = ret_entry(32'h0c, 4, 1, 32'hffff_fffd);
		exp_ret[4]  = ret_entry(32'h10, 5, 1, 32'h1234_5000);
		exp_ret[5]  = ret_entry(32'h14, 0, 1, 32'h0);
		exp_ret[6]  = ret_entry(32'h18, 15, 1, 32'h1234_5000);
		exp_ret[7]  = ret_entry(32'h1c, 6, 1, 32'h100);
		exp_ret[8]  = ret_entry(32'h20, 0, 0, 32'h0);
		exp_ret[9]  = ret_entry(32'h24, 7, 1, 32'hffff_fffd);
		exp_ret[10] = ret_entry(32'h28, 8, 1, 32'hffff_fffe);
		exp_ret[11] = ret_entry(32'h2c, 0, 0, 32'h0);
		exp_ret[12] = ret_entry(32'h30, 0, 0, 32'h0);
		exp_ret[13] = ret_entry(32'h3c, 10, 1, 32'h40);
		exp_ret[14] = ret_entry(32'h48, 12, 1, fill_word(32'h100));
		exp_ret[15] = ret_entry(32'h4c, 13, 1, fill_word(32'h100) + 32'h40);
		exp_ret[16] = ret_entry(32'h50, 0, 0, 32'h0);
		exp_ret[17] = ret_entry(32'h54, 14, 1, fill_word(32'h100) + 32'h40);
		exp_ret[18] = ret_entry(32'h58, 0, 1, 32'h0);
		exp_st[0] = {32'h108, 32'hffff_fffd};
		exp_st[1] = {32'h10c, fill_word(32'h100) + 32'h40};
	end

	// word memory, answers every strobe one cycle later
	always @(posedge clk) begin
		if (rst) begin
			mem_rsp <= '0;
		end else begin
			mem_rsp.strobe <= mem_req.strobe;
			if (mem_req.strobe) begin
				mem_rsp.rdata <= mem[mem_req.addr[9:2]];
				if (mem_req.write) begin
					mem[mem_req.addr[9:2]] <= mem_req.wdata;
				end
			end
		end
	end

	tb_clock i_clock (
		.clk,
		.rst
	);

	npc_core i_dut (
		.clk,
		.rst,
		.mem_req,
		.mem_rsp,
		.retire
	);

	assign assert_fails = i_dut.i_checker.assert_fails;

	tb_monitor #(
		.N_RET (N_RET),
		.N_ST  (N_ST)
	) i_monitor (
		.clk,
		.rst,
		.retire,
		.mem_req,
		.exp_ret,
		.exp_st,
		.assert_fails,
		.done,
		.err_count,
		.ret_count
	);

	// ****************************************
	// watchdog and end of run
	// ****************************************
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout after %0d cycles with %0d of %0d instructions retired",
				cycles, ret_count, N_RET);
			i_monitor.print_summary();
			$display("tests failed");
		end else begin
			i_monitor.print_summary();
			if (err_count == 0 && assert_fails == 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
		end
		$finish;
	end

endmodule

/* verification/tb_monitor.sv */
// testbench monitor that compares retire reports and stores against the tables
`timescale 1ns/100ps

module tb_monitor
	import npc_pkg::*;
#(
	parameter int N_RET = 1,
	parameter int N_ST  = 1
) (
	input  logic                   clk,
	input  logic                   rst,
	input  retire_t                retire,
	input  mem_req_t               mem_req,
	// {pc, rd, we, value} per entry
	input  logic [N_RET-1:0][69:0] exp_ret,
	// {addr, data} per entry
	input  logic [N_ST-1:0][63:0]  exp_st,
	input  int                     assert_fails,
	output logic                   done,
	output int                     err_count,
	output int                     ret_count
);

	int          st_count;
	logic [31:0] e_pc;
	logic [4:0]  e_rd;
	logic        e_we;
	logic [31:0] e_val;

	initial begin
		done      = 1'b0;
		err_count = 0;
		ret_count = 0;
		st_count  = 0;
	end

	// ****************************************
	// compare on the falling edge
	// ****************************************
	always @(negedge clk) begin
		if (!rst && !done) begin
			// stores seen at the external port
			if (mem_req.strobe && mem_req.write) begin
				if (st_count >= N_ST) begin
					$display("an extra store to %h was not expected at %0t",
						mem_req.addr, $time);
					err_count++;
				end else begin
					if (mem_req.addr !== exp_st[st_count][63:32] ||
							mem_req.wdata !== exp_st[st_count][31:0]) begin
						$display("Fail %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, st_count, mem_req.wdata, mem_req.addr,
							exp_st[st_count][31:0], exp_st[st_count][63:32]);
						err_count++;
					end
					st_count++;
				end
			end
			// next retire in program order
			if (retire.strobe) begin
				{e_pc, e_rd, e_we, e_val} = exp_ret[ret_count];
				if (retire.pc !== e_pc || retire.we !== e_we) begin
					$display("Fail %0t: retire %0d pc %h we %b, expected pc %h we %b",
						$time, ret_count, retire.pc, retire.we, e_pc, e_we);
					err_count++;
				end else if (e_we && (retire.rd !== e_rd || retire.value !== e_val)) begin
					$display("Fail %0t: retire %0d pc %h wrote x%0d = %h, expected x%0d = %h",
						$time, ret_count, retire.pc, retire.rd, retire.value, e_rd, e_val);
					err_count++;
				end
				ret_count++;
				if (ret_count == N_RET) begin
					if (st_count != N_ST) begin
						$display("only %0d of %0d stores reached memory", st_count, N_ST);
						err_count++;
					end
					done = 1'b1;
				end
			end
		end
	end

	// one closing line with all counts
	task automatic print_summary();
		$display({"summary: %0d value errors, %0d assertion failures, ",
			"%0d/%0d retired, %0d/%0d stores"},
			err_count, assert_fails, ret_count, N_RET, st_count, N_ST);
	endtask

endmodule

/* verification/tb_clock.sv */
// testbench clock and reset source, 4 ns period with reset held for 8 cycles
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// reset released on a rising edge
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

	always #2 clk = ~clk;

endmodule

/* verification/npc_checker.sv */
// bound assertions on the npc core memory bus, arbiter routing and stage handshakes
`timescale 1ns/100ps

module npc_checker
	import npc_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input mem_req_t   mem_req,
	input mem_rsp_t   mem_rsp,
	input mem_req_t   fetch_req,
	input mem_rsp_t   fetch_rsp,
	input mem_req_t   lsu_req,
	input mem_rsp_t   lsu_rsp,
	input logic       pend_v,
	input logic       redirect,
	input fetch_pkt_t f_pkt,
	input logic       f_valid,
	input logic       f_ready,
	input exec_pkt_t  d_pkt,
	input logic       d_valid,
	input logic       d_ready,
	input mem_pkt_t   e_pkt,
	input logic       e_valid,
	input logic       e_ready
);

	// failed assertions, read by the testbench top
	int assert_fails;

	initial assert_fails = 0;

	// ****************************************
	// memory bus timing
	// ****************************************
	a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
		mem_req.strobe |=> mem_rsp.strobe)
	else begin
		$error("bus response missing one cycle after a request");
		assert_fails++;
	end

	// answer goes to the peer that won the bus one cycle before
	a_rsp_routing: assert property (@(posedge clk) disable iff (rst)
		mem_rsp.strobe |->
		(lsu_rsp.strobe == $past(lsu_req.strobe) &&
		fetch_rsp.strobe == !$past(lsu_req.strobe)))
	else begin
		$error("bus response routed to the wrong peer");
		assert_fails++;
	end

	// parked fetch plus a fresh one would be two in flight
	a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
		pend_v |-> !fetch_req.strobe)
	else begin
		$error("new fetch request while the arbiter slot is full");
		assert_fails++;
	end

	// ****************************************
	// stage handshakes, redirect may flush
	// ****************************************
	a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
		(f_valid && !f_ready && !redirect) |=> (f_valid && $stable(f_pkt)))
	else begin
		$error("fetch packet dropped or changed while stalled");
		assert_fails++;
	end

	// operands of unused sources follow the register file, so check the control fields
	a_decode_hold: assert property (@(posedge clk) disable iff (rst)
		(d_valid && !d_ready && !redirect) |=>
		(d_valid && $stable({d_pkt.pc, d_pkt.op, d_pkt.rd, d_pkt.we})))
	else begin
		$error("decode packet dropped or changed while stalled");
		assert_fails++;
	end

	a_execute_hold: assert property (@(posedge clk) disable iff (rst)
		(e_valid && !e_ready) |=> (e_valid && $stable(e_pkt)))
	else begin
		$error("execute packet dropped or changed while stalled");
		assert_fails++;
	end

endmodule

bind npc_core npc_checker i_checker (
	.clk,
	.rst,
	.mem_req,
	.mem_rsp,
	.fetch_req,
	.fetch_rsp,
	.lsu_req,
	.lsu_rsp,
	.pend_v  (i_arbiter.pend_v),
	.redirect,
	.f_pkt,
	.f_valid,
	.f_ready,
	.d_pkt,
	.d_valid,
	.d_ready,
	.e_pkt,
	.e_valid,
	.e_ready
);

/* design/npc_core.sv */
// npc core top, four stage rv32i subset pipeline sharing one memory bus
`timescale 1ns/100ps

module npc_core
	import npc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output mem_req_t mem_req,
	input  mem_rsp_t mem_rsp,
	output retire_t  retire
);

	// ****************************************
	// stage links
	// ****************************************
	fetch_pkt_t            f_pkt;
	logic                  f_valid;
	logic                  f_ready;
	exec_pkt_t             d_pkt;
	logic                  d_valid;
	logic                  d_ready;
	mem_pkt_t              e_pkt;
	logic                  e_valid;
	logic                  e_ready;
	logic                  redirect;
	logic [XLEN-1:0]       redirect_pc;

	// register file ports
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0]       rs1_val;
	logic [XLEN-1:0]       rs2_val;
	logic                  rs1_busy;
	logic                  rs2_busy;
	logic                  reserve;
	logic [REG_ADDR_W-1:0] reserve_rd;
	logic                  wr_en;
	logic [REG_ADDR_W-1:0] wr_rd;
	logic [XLEN-1:0]       wr_val;

	// bus peers
	mem_req_t              fetch_req;
	mem_rsp_t              fetch_rsp;
	mem_req_t              lsu_req;
	mem_rsp_t              lsu_rsp;

	fetch_unit i_fetch (
		.clk,
		.rst,
		.redirect,
		.redirect_pc,
		.mem_req   (fetch_req),
		.mem_rsp   (fetch_rsp),
		.out_pkt   (f_pkt),
		.out_valid (f_valid),
		.out_ready (f_ready)
	);

	decode_unit i_decode (
		.clk,
		.rst,
		.in_pkt    (f_pkt),
		.in_valid  (f_valid),
		.in_ready  (f_ready),
		// redirect also kills the packet held in decode
		.flush     (redirect),
		.rs1,
		.rs2,
		.rs1_val,
		.rs2_val,
		.rs1_busy,
		.rs2_busy,
		.reserve,
		.reserve_rd,
		.out_pkt   (d_pkt),
		.out_valid (d_valid),
		.out_ready (d_ready)
	);

	gpr_file i_gpr (
		.clk,
		.rst,
		.rs1,
		.rs2,
		.rs1_val,
		.rs2_val,
		.rs1_busy,
		.rs2_busy,
		.reserve,
		.reserve_rd,
		.wr_en,
		.wr_rd,
		.wr_val
	);

	execute_unit i_execute (
		.clk,
		.rst,
		.in_pkt    (d_pkt),
		.in_valid  (d_valid),
		.in_ready  (d_ready),
		.redirect,
		.redirect_pc,
		.out_pkt   (e_pkt),
		.out_valid (e_valid),
		.out_ready (e_ready)
	);

	lsu i_lsu (
		.clk,
		.rst,
		.in_pkt   (e_pkt),
		.in_valid (e_valid),
		.in_ready (e_ready),
		.mem_req  (lsu_req),
		.mem_rsp  (lsu_rsp),
		.wr_en,
		.wr_rd,
		.wr_val,
		.retire
	);

	mem_arbiter i_arbiter (
		.clk,
		.rst,
		.fetch_req,
		.fetch_rsp,
		.lsu_req,
		.lsu_rsp,
		.bus_req (mem_req),
		.bus_rsp (mem_rsp)
	);

endmodule

/* design/mem_arbiter.sv */
// memory bus arbiter, lsu first, one parked fetch request, response routing
`timescale 1ns/100ps

module mem_arbiter
	import npc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  mem_req_t fetch_req,
	output mem_rsp_t fetch_rsp,
	input  mem_req_t lsu_req,
	output mem_rsp_t lsu_rsp,
	output mem_req_t bus_req,
	input  mem_rsp_t bus_rsp
);

	mem_req_t pend_q;
	logic     pend_v;
	// owner of the request answered this cycle
	logic     owner_lsu;

	// ****************************************
	// grant
	// ****************************************
	always_comb begin
		if (lsu_req.strobe) begin
			bus_req = lsu_req;
		end else if (pend_v) begin
			bus_req = pend_q;
		end else begin
			bus_req = fetch_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_v    <= 1'b0;
			owner_lsu <= 1'b0;
		end else begin
			// fetch loses to lsu, keep it for next cycle
			pend_v    <= lsu_req.strobe && (fetch_req.strobe || pend_v);
			owner_lsu <= lsu_req.strobe;
		end
		// fetch has one request outstanding, slot never overflows
		if (fetch_req.strobe) begin
			pend_q <= fetch_req;
		end
	end

	// response goes back to its owner only
	assign fetch_rsp = '{strobe: bus_rsp.strobe && !owner_lsu, rdata: bus_rsp.rdata};
	assign lsu_rsp   = '{strobe: bus_rsp.strobe && owner_lsu, rdata: bus_rsp.rdata};

endmodule

/* design/lsu.sv */
// load/store unit with writeback and retire report
`timescale 1ns/100ps

module lsu
	import npc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  mem_pkt_t              in_pkt,
	input  logic                  in_valid,
	output logic                  in_ready,
	output mem_req_t              mem_req,
	input  mem_rsp_t              mem_rsp,
	output logic                  wr_en,
	output logic [REG_ADDR_W-1:0] wr_rd,
	output logic [XLEN-1:0]       wr_val,
	output retire_t               retire
);

	mem_pkt_t        pkt_q;
	logic            busy;
	logic            req_stb;
	logic            ret_stb;
	logic [XLEN-1:0] ret_val;
	logic            is_mem;

	assign is_mem   = (in_pkt.op == LOAD) || (in_pkt.op == STORE);
	// one bus access at a time
	assign in_ready = !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			req_stb <= 1'b0;
			ret_stb <= 1'b0;
		end else begin
			req_stb <= 1'b0;
			ret_stb <= 1'b0;
			if (in_valid && in_ready) begin
				busy    <= is_mem;
				req_stb <= is_mem;
				// alu ops and jumps retire next cycle
				ret_stb <= !is_mem;
			end else if (busy && mem_rsp.strobe) begin
				busy    <= 1'b0;
				ret_stb <= 1'b1;
			end
		end
		// payload
		if (in_valid && in_ready) begin
			pkt_q   <= in_pkt;
			ret_val <= in_pkt.result;
		end else if (busy && mem_rsp.strobe && pkt_q.op == LOAD) begin
			ret_val <= mem_rsp.rdata;
		end
	end

	// ****************************************
	// bus request and writeback
	// ****************************************
	assign mem_req = '{
		strobe: req_stb,
		write:  pkt_q.op == STORE,
		addr:   pkt_q.result,
		wdata:  pkt_q.store_data
	};

	// x0 reports zero
	assign retire = '{
		strobe: ret_stb,
		pc:     pkt_q.pc,
		rd:     pkt_q.rd,
		we:     pkt_q.we,
		value:  (pkt_q.rd == '0) ? '0 : ret_val
	};

	assign wr_en  = ret_stb && pkt_q.we;
	assign wr_rd  = pkt_q.rd;
	assign wr_val = retire.value;

endmodule

/* design/execute_unit.sv */
// execute stage, alu, beq compare and branch / jump redirect
`timescale 1ns/100ps

module execute_unit
	import npc_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  exec_pkt_t       in_pkt,
	input  logic            in_valid,
	output logic            in_ready,
	output logic            redirect,
	output logic [XLEN-1:0] redirect_pc,
	output mem_pkt_t        out_pkt,
	output logic            out_valid,
	input  logic            out_ready
);

	exec_pkt_t       pkt_q;
	logic            valid_q;
	logic [XLEN-1:0] alu_out;
	logic            taken;

	// ****************************************
	// input register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (out_ready || !valid_q) begin
			valid_q <= in_valid && in_ready;
		end
		if (in_valid && in_ready) begin
			pkt_q <= in_pkt;
		end
	end

	// alu, also effective address and jal link
	always_comb begin
		case (pkt_q.alu_mode)
			ALU_SUB:    alu_out = pkt_q.a - pkt_q.b;
			ALU_PASS_B: alu_out = pkt_q.b;
			default:    alu_out = pkt_q.a + pkt_q.b;
		endcase
	end

	assign taken = (pkt_q.op == JAL) || (pkt_q.op == BRANCH && pkt_q.a == pkt_q.b);

	// redirect only in the cycle the branch moves on
	assign redirect    = valid_q && taken && out_ready;
	assign redirect_pc = pkt_q.pc + pkt_q.imm;

	// younger packet in decode is wrong path during a redirect
	assign in_ready = (!valid_q || out_ready) && !redirect;

	assign out_valid = valid_q;
	assign out_pkt   = '{
		pc:         pkt_q.pc,
		result:     alu_out,
		store_data: pkt_q.store_data,
		op:         pkt_q.op,
		rd:         pkt_q.rd,
		we:         pkt_q.we
	};

endmodule

/* design/decode_unit.sv */
// decode stage, field split, immediates, operand read and scoreboard stall
`timescale 1ns/100ps

module decode_unit
	import npc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  fetch_pkt_t            in_pkt,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic                  flush,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	input  logic [XLEN-1:0]       rs1_val,
	input  logic [XLEN-1:0]       rs2_val,
	input  logic                  rs1_busy,
	input  logic                  rs2_busy,
	output logic                  reserve,
	output logic [REG_ADDR_W-1:0] reserve_rd,
	output exec_pkt_t             out_pkt,
	output logic                  out_valid,
	input  logic                  out_ready
);

	fetch_pkt_t      pkt_q;
	logic            valid_q;
	logic [31:0]     ins;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic            use_rs1;
	logic            use_rs2;
	logic            hazard;
	exec_pkt_t       pkt;

	// held fetch packet, flush kills it and anything arriving
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
		if (in_valid && in_ready) begin
			pkt_q <= in_pkt;
		end
	end

	// ****************************************
	// fields and immediates
	// ****************************************
	assign ins    = pkt_q.instr;
	assign funct3 = ins[14:12];
	assign funct7 = ins[31:25];
	assign rs1    = ins[19:15];
	assign rs2    = ins[24:20];

	assign imm_i = {{20{ins[31]}}, ins[31:20]};
	assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_u = {ins[31:12], 12'b0};
	assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

	// operand select per opcode
	always_comb begin
		pkt.pc         = pkt_q.pc;
		pkt.a          = rs1_val;
		pkt.b          = rs2_val;
		pkt.store_data = rs2_val;
		pkt.imm        = imm_i;
		pkt.alu_mode   = ALU_ADD;
		// unknown encodings fall through as a no-write no-op
		pkt.op         = OP_IMM;
		pkt.rd         = ins[11:7];
		pkt.we         = 1'b0;
		use_rs1        = 1'b0;
		use_rs2        = 1'b0;
		case (ins[6:0])
			OP_IMM: begin
				if (funct3 == 3'b000) begin
					pkt.b   = imm_i;
					pkt.we  = 1'b1;
					use_rs1 = 1'b1;
				end
			end
			OP: begin
				// add / sub only, funct7 bit 5 picks sub
				if (funct3 == 3'b000 && {funct7[6], funct7[4:0]} == 6'b0) begin
					pkt.op       = OP;
					pkt.alu_mode = funct7[5] ? ALU_SUB : ALU_ADD;
					pkt.we       = 1'b1;
					use_rs1      = 1'b1;
					use_rs2      = 1'b1;
				end
			end
			LUI: begin
				pkt.op       = LUI;
				pkt.b        = imm_u;
				pkt.alu_mode = ALU_PASS_B;
				pkt.we       = 1'b1;
			end
			LOAD: begin
				if (funct3 == 3'b010) begin
					pkt.op  = LOAD;
					pkt.b   = imm_i;
					pkt.we  = 1'b1;
					use_rs1 = 1'b1;
				end
			end
			STORE: begin
				if (funct3 == 3'b010) begin
					pkt.op  = STORE;
					pkt.b   = imm_s;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			BRANCH: begin
				if (funct3 == 3'b000) begin
					pkt.op       = BRANCH;
					pkt.imm      = imm_b;
					pkt.alu_mode = ALU_SUB;
					use_rs1      = 1'b1;
					use_rs2      = 1'b1;
				end
			end
			JAL: begin
				// alu makes the link value pc + 4
				pkt.op  = JAL;
				pkt.a   = pkt_q.pc;
				pkt.b   = 32'd4;
				pkt.imm = imm_j;
				pkt.we  = 1'b1;
			end
			default: ;
		endcase
	end

	// raw stall on a busy source
	assign hazard = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);

	assign out_pkt    = pkt;
	assign out_valid  = valid_q && !hazard;
	assign in_ready   = !valid_q || (out_valid && out_ready);
	assign reserve    = out_valid && out_ready && pkt.we;
	assign reserve_rd = pkt.rd;

endmodule

/* design/gpr_file.sv */
// general register file, 32 x 32 bit with x0 tied to zero and a busy scoreboard
`timescale 1ns/100ps

module gpr_file
	import npc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	output logic [XLEN-1:0]       rs1_val,
	output logic [XLEN-1:0]       rs2_val,
	output logic                  rs1_busy,
	output logic                  rs2_busy,
	input  logic                  reserve,
	input  logic [REG_ADDR_W-1:0] reserve_rd,
	input  logic                  wr_en,
	input  logic [REG_ADDR_W-1:0] wr_rd,
	input  logic [XLEN-1:0]       wr_val
);

	logic [XLEN-1:0]            regs [2**REG_ADDR_W];
	logic [2**REG_ADDR_W-1:0]   busy;

	// x0 never written
	always_ff @(posedge clk) begin
		if (wr_en && wr_rd != '0) begin
			regs[wr_rd] <= wr_val;
		end
	end

	// ****************************************
	// scoreboard
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (wr_en) begin
				busy[wr_rd] <= 1'b0;
			end
			// later assignment, so reserve wins on a clash
			if (reserve && reserve_rd != '0) begin
				busy[reserve_rd] <= 1'b1;
			end
		end
	end

	assign rs1_val  = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val  = (rs2 == '0) ? '0 : regs[rs2];
	assign rs1_busy = busy[rs1];
	assign rs2_busy = busy[rs2];

endmodule

/* design/fetch_unit.sv */
// fetch unit, keeps the pc and runs one instruction fetch at a time with redirect
`timescale 1ns/100ps

module fetch_unit
	import npc_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect,
	input  logic [XLEN-1:0] redirect_pc,
	output mem_req_t        mem_req,
	input  mem_rsp_t        mem_rsp,
	output fetch_pkt_t      out_pkt,
	output logic            out_valid,
	input  logic            out_ready
);

	// idle only right after reset
	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_HOLD
	} state_e;

	state_e          state;
	logic [XLEN-1:0] pc;
	logic [31:0]     instr;
	logic            req_stb;
	// outstanding answer belongs to the old path
	logic            stale;

	// request address is always the current pc
	assign mem_req = '{strobe: req_stb, write: 1'b0, addr: pc, wdata: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= S_IDLE;
			pc      <= RESET_PC;
			req_stb <= 1'b0;
			stale   <= 1'b0;
		end else begin
			req_stb <= 1'b0;
			if (redirect) begin
				pc <= redirect_pc;
				if (state == S_WAIT && !mem_rsp.strobe) begin
					// answer still on its way, throw it away later
					stale <= 1'b1;
				end else begin
					// bus is free, go to the target right away
					req_stb <= 1'b1;
					stale   <= 1'b0;
					state   <= S_WAIT;
				end
			end else begin
				case (state)
					S_IDLE: begin
						req_stb <= 1'b1;
						state   <= S_WAIT;
					end
					S_WAIT: begin
						if (mem_rsp.strobe && stale) begin
							// old path word dropped, refetch at new pc
							req_stb <= 1'b1;
							stale   <= 1'b0;
						end else if (mem_rsp.strobe) begin
							state <= S_HOLD;
						end
					end
					S_HOLD: begin
						if (out_ready) begin
							pc      <= pc + 32'd4;
							req_stb <= 1'b1;
							state   <= S_WAIT;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// instruction word capture
	always_ff @(posedge clk) begin
		if (state == S_WAIT && mem_rsp.strobe) begin
			instr <= mem_rsp.rdata;
		end
	end

	assign out_valid = (state == S_HOLD);
	assign out_pkt   = '{pc: pc, instr: instr};

endmodule

/* common/npc_pkg.sv */
// npc core shared widths, opcodes, alu modes and packed bus / pipeline structs
package npc_pkg;

	// ****************************************
	// widths and reset values
	// ****************************************
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// major opcodes, rv32i encoding of inst[6:0]
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} op_e;

	// alu function, chosen in decode
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B
	} alu_mode_e;

	// ****************************************
	// memory bus, single cycle strobes
	// ****************************************
	typedef struct packed {
		logic            strobe;
		logic            write;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic            strobe;
		logic [XLEN-1:0] rdata;
	} mem_rsp_t;

	// ****************************************
	// pipeline packets
	// ****************************************
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       a;
		logic [XLEN-1:0]       b;
		logic [XLEN-1:0]       store_data;
		logic [XLEN-1:0]       imm;
		alu_mode_e             alu_mode;
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic                  we;
	} exec_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		// alu result, link value or effective address
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       store_data;
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic                  we;
	} mem_pkt_t;

	// one entry per retired instruction
	typedef struct packed {
		logic                  strobe;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  we;
		logic [XLEN-1:0]       value;
	} retire_t;

endpackage
